/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= core_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/core_sva.sv */
`timescale 1ns/1ps

module core_sva (
  input logic               clk,
  input logic               nreset,
  input core_pkg::decoded_t dec_i,
  input core_pkg::wb_t      wb_i,
  input core_pkg::flags_t   flags_i
);

  // result register cleared while reset is held
  wb_low_in_reset: assert property (@(posedge clk) !nreset |=> !wb_i.valid)
    else $error("wb valid set while reset is held");

  wb_valid_known: assert property (@(posedge clk) disable iff (!nreset)
    !$isunknown(wb_i.valid))
    else $error("wb valid is unknown");

  // no instruction in execute, nzcv must not move
  flags_hold_idle: assert property (@(posedge clk) disable iff (!nreset)
    !dec_i.valid |=> $stable(flags_i))
    else $error("flags changed without an instruction in execute");

endmodule

bind core_top core_sva u_sva (
  .clk     (clk),
  .nreset  (nreset),
  .dec_i   (dec),
  .wb_i    (wb_o),
  .flags_i (flags_o)
);

/* bench/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

  // one table row with hand-worked expected values
  typedef struct packed {
    logic [31:0] instr;
    logic        wr;
    logic [3:0]  rd;
    logic [31:0] data;
    logic [3:0]  flags;
  } test_t;

  localparam core_pkg::cond_e AL = core_pkg::COND_AL;

  logic                        clk = 1'b0;
  logic                        nreset;
  logic                        instr_valid;
  logic [core_pkg::DATA_W-1:0] instr_word;
  core_pkg::wb_t               wb;
  core_pkg::flags_t            flags;

  test_t       tests[$];
  int          exp_idx[$];
  int unsigned exp_due[$];
  int unsigned cycle = 0;
  int          errors = 0;
  int          checked = 0;
  logic        table_ready = 1'b0;

  core_top u_dut (
    .clk           (clk),
    .nreset        (nreset),
    .instr_valid_i (instr_valid),
    .instr_i       (instr_word),
    .wb_o          (wb),
    .flags_o       (flags)
  );

  always #5 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // data-processing word with imm or rm in the low byte
  function automatic logic [31:0] encode(input core_pkg::cond_e cond, input int imm_sel,
                                         input core_pkg::alu_op_e op, input int s,
                                         input int rn, input int rd, input int op2);
    return {cond, 2'b00, imm_sel[0], op, s[0], rn[3:0], rd[3:0], 4'h0, op2[7:0]};
  endfunction

  function automatic void add_test(input logic [31:0] instr, input int wr, input int rd,
                                   input logic [31:0] data, input logic [3:0] flags_exp);
    test_t t;
    t.instr = instr;
    t.wr    = wr[0];
    t.rd    = rd[3:0];
    t.data  = data;
    t.flags = flags_exp;
    tests.push_back(t);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table with flags as nzcv
  ////////////////////////////////////////////////////////////////////////////
  task automatic build_table();
    add_test(encode(AL, 1, core_pkg::OP_MOV, 0, 0, 1, 'h5A), 1, 1, 32'h5A, 4'b0000);
    add_test(encode(AL, 1, core_pkg::OP_MOV, 0, 0, 2, 'hFF), 1, 2, 32'hFF, 4'b0000);
    add_test(encode(AL, 1, core_pkg::OP_ADD, 1, 1, 3, 'h10), 1, 3, 32'h6A, 4'b0000);
    add_test(encode(AL, 0, core_pkg::OP_ADD, 1, 1, 4, 2), 1, 4, 32'h159, 4'b0000);
    add_test(encode(AL, 1, core_pkg::OP_SUB, 1, 4, 5, 'h59), 1, 5, 32'h100, 4'b0010);
    // borrow and negative result
    add_test(encode(AL, 0, core_pkg::OP_SUB, 1, 1, 6, 2), 1, 6, 32'hFFFFFF5B, 4'b1000);
    // carry out to zero
    add_test(encode(AL, 1, core_pkg::OP_ADD, 1, 6, 10, 'hA5), 1, 10, 32'h0, 4'b0110);
    add_test(encode(AL, 1, core_pkg::OP_MOV, 0, 0, 8, 'h40), 1, 8, 32'h40, 4'b0110);
    // doubling chain up to bit 30 without S
    for (int i = 1; i <= 24; i++) begin
      add_test(encode(AL, 0, core_pkg::OP_ADD, 0, 8, 8, 8), 1, 8, 32'h40 << i, 4'b0110);
    end
    // signed overflow on add and sub
    add_test(encode(AL, 0, core_pkg::OP_ADD, 1, 8, 9, 8), 1, 9, 32'h80000000, 4'b1001);
    add_test(encode(AL, 1, core_pkg::OP_SUB, 1, 9, 11, 1), 1, 11, 32'h7FFFFFFF, 4'b0011);
    add_test(encode(AL, 1, core_pkg::OP_ADD, 1, 11, 12, 1), 1, 12, 32'h80000000, 4'b1001);
    add_test(encode(AL, 0, core_pkg::OP_SUB, 1, 12, 12, 11), 1, 12, 32'h1, 4'b0011);
    // compares and conditional moves
    add_test(encode(AL, 1, core_pkg::OP_CMP, 1, 1, 0, 'h5A), 0, 0, 32'h0, 4'b0110);
    add_test(encode(core_pkg::COND_EQ, 1, core_pkg::OP_MOV, 0, 0, 13, 'h11), 1, 13, 32'h11, 4'b0110);
    add_test(encode(core_pkg::COND_NE, 1, core_pkg::OP_MOV, 0, 0, 13, 'h22), 0, 0, 32'h0, 4'b0110);
    add_test(encode(AL, 0, core_pkg::OP_CMP, 1, 1, 0, 2), 0, 0, 32'h0, 4'b1000);
    add_test(encode(core_pkg::COND_LT, 1, core_pkg::OP_MOV, 0, 0, 13, 'h33), 1, 13, 32'h33, 4'b1000);
    add_test(encode(core_pkg::COND_GE, 1, core_pkg::OP_MOV, 0, 0, 13, 'h44), 0, 0, 32'h0, 4'b1000);
    add_test(encode(core_pkg::COND_LS, 1, core_pkg::OP_MOV, 0, 0, 13, 'h55), 1, 13, 32'h55, 4'b1000);
    add_test(encode(core_pkg::COND_HI, 1, core_pkg::OP_MOV, 0, 0, 13, 'h66), 0, 0, 32'h0, 4'b1000);
    add_test(encode(AL, 1, core_pkg::OP_TST, 1, 2, 0, 'h0F), 0, 0, 32'h0, 4'b0000);
    add_test(encode(AL, 1, core_pkg::OP_TEQ, 1, 1, 0, 'h5A), 0, 0, 32'h0, 4'b0100);
    add_test(encode(AL, 0, core_pkg::OP_CMP, 1, 2, 0, 1), 0, 0, 32'h0, 4'b0010);
    add_test(encode(core_pkg::COND_HI, 1, core_pkg::OP_ADD, 0, 12, 14, 1), 1, 14, 32'h2, 4'b0010);
    // logical ops keep c and v
    add_test(encode(AL, 1, core_pkg::OP_CMP, 1, 9, 0, 1), 0, 0, 32'h0, 4'b0011);
    add_test(encode(AL, 0, core_pkg::OP_EOR, 1, 1, 3, 2), 1, 3, 32'hA5, 4'b0011);
    add_test(encode(AL, 0, core_pkg::OP_ORR, 1, 3, 4, 14), 1, 4, 32'hA7, 4'b0011);
    add_test(encode(AL, 1, core_pkg::OP_BIC, 1, 2, 5, 'h0F), 1, 5, 32'hF0, 4'b0011);
    add_test(encode(AL, 1, core_pkg::OP_MVN, 1, 0, 6, 'h00), 1, 6, 32'hFFFFFFFF, 4'b1011);
    add_test(encode(AL, 0, core_pkg::OP_BIC, 1, 6, 7, 6), 1, 7, 32'h0, 4'b0111);
    add_test(encode(core_pkg::COND_NV, 0, core_pkg::OP_MVN, 1, 0, 7, 1), 0, 0, 32'h0, 4'b0111);
    // result written with flags untouched
    add_test(encode(AL, 0, core_pkg::OP_MVN, 0, 0, 2, 6), 1, 2, 32'h0, 4'b0111);
    add_test(encode(AL, 1, core_pkg::OP_ORR, 0, 2, 2, 'h3C), 1, 2, 32'h3C, 4'b0111);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checker two edges after the drive
  ////////////////////////////////////////////////////////////////////////////
  task automatic check_result(input int idx);
    test_t t;
    int    bad;
    t   = tests[idx];
    bad = 0;
    assert (wb.valid == t.wr) else begin
      $display("[FAIL] %0t test %0d: wb valid %0b, expected %0b", $time, idx, wb.valid, t.wr);
      bad++;
    end
    if (t.wr) begin
      assert (wb.addr == t.rd && wb.data == t.data) else begin
        $display("[FAIL] %0t test %0d: wrote r%0d=%h, expected r%0d=%h", $time, idx,
                 wb.addr, wb.data, t.rd, t.data);
        bad++;
      end
    end
    assert (flags == t.flags) else begin
      $display("[FAIL] %0t test %0d: flags %b, expected %b", $time, idx, flags, t.flags);
      bad++;
    end
    errors += bad;
    checked++;
    $display("test %0d instr %h %s", idx, t.instr, (bad == 0) ? "ok" : "mismatch");
  endtask

  always @(negedge clk) begin
    if (exp_idx.size() != 0 && exp_due[0] == cycle) begin
      check_result(exp_idx.pop_front());
      void'(exp_due.pop_front());
    end
  end

  // watchdog sized from the table
  initial begin
    wait (table_ready);
    repeat (tests.size() * 20 + 50) @(posedge clk);
    $display("timeout: run still busy after %0d table entries' worth of cycles", tests.size());
    $display("Something failed");
    $finish;
  end

  initial begin
    int gap;
    nreset      = 1'b0;
    instr_valid = 1'b0;
    instr_word  = '0;
    $timeformat(-9, 0, " ns", 0);
    void'($urandom(32'h7f8fb0be));
    build_table();
    table_ready = 1'b1;
    repeat (5) @(posedge clk);
    #1 nreset = 1'b1;
    @(negedge clk);
    assert (wb.valid == 1'b0 && flags == 4'b0000) else begin
      $display("[FAIL] %0t after reset: wb valid %0b, flags %b", $time, wb.valid, flags);
      errors++;
    end
    foreach (tests[i]) begin
      @(posedge clk);
      #1;
      instr_valid = 1'b1;
      instr_word  = tests[i].instr;
      exp_idx.push_back(i);
      exp_due.push_back(cycle + 2);
      // random idle cycles before the next entry
      gap = $urandom % 3;
      repeat (gap) begin
        @(posedge clk);
        #1 instr_valid = 1'b0;
      end
    end
    @(posedge clk);
    #1 instr_valid = 1'b0;
    while (exp_idx.size() != 0) @(negedge clk);
    $display("checked %0d of %0d tests, %0d errors", checked, tests.size(), errors);
    if (errors == 0 && checked == tests.size()) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
  input  core_pkg::alu_op_e           op_i,
  input  logic [core_pkg::DATA_W-1:0] op1_i,
  input  logic [core_pkg::DATA_W-1:0] op2_i,
  input  core_pkg::flags_t            flags_i,
  output logic [core_pkg::DATA_W-1:0] result_o,
  output core_pkg::flags_t            flags_o
);

  // one extra bit for the carry out
  logic [core_pkg::DATA_W:0]   sum;
  logic [core_pkg::DATA_W:0]   diff;
  logic                        add_ovf;
  logic                        sub_ovf;

  // op1 + op2
  assign sum     = {1'b0, op1_i} + {1'b0, op2_i};
  // op1 - op2 as op1 + ~op2 + 1, carry out set means no borrow
  assign diff    = {1'b0, op1_i} + {1'b0, ~op2_i} + 1'b1;
  // signed overflow, same-sign inputs giving a flipped sign
  assign add_ovf = (op1_i[core_pkg::DATA_W-1] == op2_i[core_pkg::DATA_W-1]) &&
                   (sum[core_pkg::DATA_W-1] != op1_i[core_pkg::DATA_W-1]);
  // for sub the signs must differ
  assign sub_ovf = (op1_i[core_pkg::DATA_W-1] != op2_i[core_pkg::DATA_W-1]) &&
                   (diff[core_pkg::DATA_W-1] != op1_i[core_pkg::DATA_W-1]);

  always_comb begin
    // logical ops keep c and v
    flags_o.c = flags_i.c;
    flags_o.v = flags_i.v;
    case (op_i)
      core_pkg::OP_ADD: begin
        result_o  = sum[core_pkg::DATA_W-1:0];
        flags_o.c = sum[core_pkg::DATA_W];
        flags_o.v = add_ovf;
      end
      core_pkg::OP_SUB, core_pkg::OP_CMP: begin
        result_o  = diff[core_pkg::DATA_W-1:0];
        flags_o.c = diff[core_pkg::DATA_W];
        flags_o.v = sub_ovf;
      end
      core_pkg::OP_EOR, core_pkg::OP_TEQ: result_o = op1_i ^ op2_i;
      core_pkg::OP_TST: result_o = op1_i & op2_i;
      core_pkg::OP_ORR: result_o = op1_i | op2_i;
      core_pkg::OP_BIC: result_o = op1_i & ~op2_i;
      core_pkg::OP_MVN: result_o = ~op2_i;
      core_pkg::OP_MOV: result_o = op2_i;
      default: result_o = '0;
    endcase
    // n and z from whatever came out
    flags_o.n = result_o[core_pkg::DATA_W-1];
    flags_o.z = (result_o == '0);
  end

endmodule

/* design/core_pkg.sv */
package core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////
  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 4;
  localparam int NUM_REGS   = 16;
  localparam int IMM_W      = 8;

  // data-processing opcodes, instr[24:21]
  // and (0000) and the rest are not supported
  typedef enum logic [3:0] {
    OP_EOR = 4'b0001,
    OP_SUB = 4'b0010,
    OP_ADD = 4'b0100,
    OP_TST = 4'b1000,
    OP_TEQ = 4'b1001,
    OP_CMP = 4'b1010,
    OP_ORR = 4'b1100,
    OP_MOV = 4'b1101,
    OP_BIC = 4'b1110,
    OP_MVN = 4'b1111
  } alu_op_e;

  // condition field, instr[31:28]
  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC,
    COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT,
    COND_GT, COND_LE, COND_AL, COND_NV
  } cond_e;

  // nzcv, msb first like the cpsr top nibble
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // one decoded instruction between decode and execute
  typedef struct packed {
    logic                  valid;
    cond_e                 cond;
    alu_op_e               op;
    logic                  imm_sel;
    logic                  set_flags;
    logic                  writes_rd;
    logic [REG_ADDR_W-1:0] rn;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rm;
    logic [IMM_W-1:0]      imm;
  } decoded_t;

  // writeback bus
  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     data;
  } wb_t;

endpackage

/* design/core_top.sv */
`timescale 1ns/1ps

module core_top (
  input  logic                        clk,
  input  logic                        nreset,
  input  logic                        instr_valid_i,
  input  logic [core_pkg::DATA_W-1:0] instr_i,
  output core_pkg::wb_t               wb_o,
  output core_pkg::flags_t            flags_o
);

  // decode to execute and register file
  core_pkg::decoded_t                  dec;
  logic [core_pkg::REG_ADDR_W-1:0]     rd_addr1;
  logic [core_pkg::REG_ADDR_W-1:0]     rd_addr2;
  logic [core_pkg::DATA_W-1:0]         rd_data1;
  logic [core_pkg::DATA_W-1:0]         rd_data2;
  // execute <-> flag unit
  logic                                flag_update;
  core_pkg::flags_t                    flags_next;
  core_pkg::cond_e                     cond;
  logic                                cond_pass;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1, decode
  ////////////////////////////////////////////////////////////////////////////
  decode_stage u_decode (
    .clk           (clk),
    .nreset        (nreset),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .dec_o         (dec),
    .rd_addr1_o    (rd_addr1),
    .rd_addr2_o    (rd_addr2)
  );

  // write port fed straight from the result register
  reg_file u_reg_file (
    .clk        (clk),
    .rd_addr1_i (rd_addr1),
    .rd_addr2_i (rd_addr2),
    .rd_data1_o (rd_data1),
    .rd_data2_o (rd_data2),
    .wb_i       (wb_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // stage 2, execute and flags
  ////////////////////////////////////////////////////////////////////////////
  execute_stage u_execute (
    .clk           (clk),
    .nreset        (nreset),
    .dec_i         (dec),
    .rd_data1_i    (rd_data1),
    .rd_data2_i    (rd_data2),
    .flags_i       (flags_o),
    .cond_pass_i   (cond_pass),
    .flag_update_o (flag_update),
    .flags_next_o  (flags_next),
    .cond_o        (cond),
    .wb_o          (wb_o)
  );

  flag_unit u_flag_unit (
    .clk          (clk),
    .nreset       (nreset),
    .cond_i       (cond),
    .update_i     (flag_update),
    .flags_next_i (flags_next),
    .flags_o      (flags_o),
    .cond_pass_o  (cond_pass)
  );

endmodule

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
  input  logic                            clk,
  input  logic                            nreset,
  input  logic                            instr_valid_i,
  input  logic [core_pkg::DATA_W-1:0]     instr_i,
  output core_pkg::decoded_t              dec_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rd_addr1_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rd_addr2_o
);

  core_pkg::decoded_t dec_d;
  core_pkg::decoded_t dec_q;
  logic               s_bit;

  assign s_bit = instr_i[20];

  // split the word into fields
  always_comb begin
    dec_d.valid   = instr_valid_i;
    dec_d.cond    = core_pkg::cond_e'(instr_i[31:28]);
    dec_d.op      = core_pkg::alu_op_e'(instr_i[24:21]);
    dec_d.imm_sel = instr_i[25];
    dec_d.rn      = instr_i[19:16];
    dec_d.rd      = instr_i[15:12];
    // rm overlaps the low imm bits, no shifter
    dec_d.rm      = instr_i[3:0];
    dec_d.imm     = instr_i[core_pkg::IMM_W-1:0];
    // write and flag control per opcode
    case (dec_d.op)
      core_pkg::OP_TST, core_pkg::OP_TEQ, core_pkg::OP_CMP: begin
        // compares always set flags, never write
        dec_d.writes_rd = 1'b0;
        dec_d.set_flags = 1'b1;
      end
      core_pkg::OP_EOR, core_pkg::OP_SUB, core_pkg::OP_ADD, core_pkg::OP_ORR,
      core_pkg::OP_MOV, core_pkg::OP_BIC, core_pkg::OP_MVN: begin
        dec_d.writes_rd = 1'b1;
        dec_d.set_flags = s_bit;
      end
      default: begin
        // unsupported code, behaves as a nop
        dec_d.writes_rd = 1'b0;
        dec_d.set_flags = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    // payload only moves on a valid word
    if (instr_valid_i) begin
      dec_q <= dec_d;
    end
    // valid bit overrides the payload load
    if (!nreset) begin
      dec_q.valid <= 1'b0;
    end else begin
      dec_q.valid <= instr_valid_i;
    end
  end

  assign dec_o      = dec_q;
  // read addresses from the registered fields
  assign rd_addr1_o = dec_q.rn;
  assign rd_addr2_o = dec_q.rm;

endmodule

/* design/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
  input  logic                        clk,
  input  logic                        nreset,
  input  core_pkg::decoded_t          dec_i,
  input  logic [core_pkg::DATA_W-1:0] rd_data1_i,
  input  logic [core_pkg::DATA_W-1:0] rd_data2_i,
  input  core_pkg::flags_t            flags_i,
  input  logic                        cond_pass_i,
  output logic                        flag_update_o,
  output core_pkg::flags_t            flags_next_o,
  output core_pkg::cond_e             cond_o,
  output core_pkg::wb_t               wb_o
);

  logic [core_pkg::DATA_W-1:0] op1;
  logic [core_pkg::DATA_W-1:0] rm_val;
  logic [core_pkg::DATA_W-1:0] op2;
  logic [core_pkg::DATA_W-1:0] imm_ext;
  logic [core_pkg::DATA_W-1:0] alu_result;
  logic                        fwd1;
  logic                        fwd2;
  logic                        commit;
  core_pkg::wb_t               wb_q;

  ////////////////////////////////////////////////////////////////////////////
  // operand forwarding and selection
  ////////////////////////////////////////////////////////////////////////////
  // previous result still in wb_q, not yet in the register file
  assign fwd1    = wb_q.valid && (wb_q.addr == dec_i.rn);
  assign fwd2    = wb_q.valid && (wb_q.addr == dec_i.rm);
  assign op1     = fwd1 ? wb_q.data : rd_data1_i;
  assign rm_val  = fwd2 ? wb_q.data : rd_data2_i;
  // 8-bit immediate, zero extended, no rotate
  assign imm_ext = {{(core_pkg::DATA_W-core_pkg::IMM_W){1'b0}}, dec_i.imm};
  assign op2     = dec_i.imm_sel ? imm_ext : rm_val;

  alu u_alu (
    .op_i     (dec_i.op),
    .op1_i    (op1),
    .op2_i    (op2),
    .flags_i  (flags_i),
    .result_o (alu_result),
    .flags_o  (flags_next_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // conditional commit
  ////////////////////////////////////////////////////////////////////////////
  // flag unit checks the cond field combinationally
  assign cond_o        = dec_i.cond;
  assign commit        = dec_i.valid && cond_pass_i;
  assign flag_update_o = commit && dec_i.set_flags;

  // result register, doubles as the forwarding source
  always_ff @(posedge clk) begin
    wb_q.addr <= dec_i.rd;
    wb_q.data <= alu_result;
    if (!nreset) begin
      wb_q.valid <= 1'b0;
    end else begin
      wb_q.valid <= commit && dec_i.writes_rd;
    end
  end

  assign wb_o = wb_q;

endmodule

/* design/flag_unit.sv */
`timescale 1ns/1ps

module flag_unit (
  input  logic             clk,
  input  logic             nreset,
  input  core_pkg::cond_e  cond_i,
  input  logic             update_i,
  input  core_pkg::flags_t flags_next_i,
  output core_pkg::flags_t flags_o,
  output logic             cond_pass_o
);

  core_pkg::flags_t flags_q;

  ////////////////////////////////////////////////////////////////////////////
  // nzcv register
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!nreset) begin
      flags_q <= '0;
    end else if (update_i) begin
      flags_q <= flags_next_i;
    end
  end

  assign flags_o = flags_q;

  ////////////////////////////////////////////////////////////////////////////
  // condition check against the current flags
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (cond_i)
      core_pkg::COND_EQ: cond_pass_o = flags_q.z;
      core_pkg::COND_NE: cond_pass_o = !flags_q.z;
      // carry set, unsigned higher or same
      core_pkg::COND_CS: cond_pass_o = flags_q.c;
      core_pkg::COND_CC: cond_pass_o = !flags_q.c;
      core_pkg::COND_MI: cond_pass_o = flags_q.n;
      core_pkg::COND_PL: cond_pass_o = !flags_q.n;
      core_pkg::COND_VS: cond_pass_o = flags_q.v;
      core_pkg::COND_VC: cond_pass_o = !flags_q.v;
      // unsigned higher / lower or same
      core_pkg::COND_HI: cond_pass_o = flags_q.c && !flags_q.z;
      core_pkg::COND_LS: cond_pass_o = !flags_q.c || flags_q.z;
      // signed compares, n == v means ge
      core_pkg::COND_GE: cond_pass_o = (flags_q.n == flags_q.v);
      core_pkg::COND_LT: cond_pass_o = (flags_q.n != flags_q.v);
      core_pkg::COND_GT: cond_pass_o = !flags_q.z && (flags_q.n == flags_q.v);
      core_pkg::COND_LE: cond_pass_o = flags_q.z || (flags_q.n != flags_q.v);
      core_pkg::COND_AL: cond_pass_o = 1'b1;
      // nv never executes
      default: cond_pass_o = 1'b0;
    endcase
  end

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                            clk,
  input  logic [core_pkg::REG_ADDR_W-1:0] rd_addr1_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] rd_addr2_i,
  output logic [core_pkg::DATA_W-1:0]     rd_data1_o,
  output logic [core_pkg::DATA_W-1:0]     rd_data2_o,
  input  core_pkg::wb_t                   wb_i
);

  // r0..r15, r15 is a plain register here
  logic [core_pkg::DATA_W-1:0] regs [core_pkg::NUM_REGS];

  ////////////////////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wb_i.valid) begin
      regs[wb_i.addr] <= wb_i.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read ports
  ////////////////////////////////////////////////////////////////////////////
  // asynchronous reads
  // same-cycle write hazard is handled by forwarding in execute
  assign rd_data1_o = regs[rd_addr1_i];
  assign rd_data2_o = regs[rd_addr2_i];

endmodule

/* vlog.f */
design/core_pkg.sv
design/reg_file.sv
design/alu.sv
design/flag_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/core_top.sv
bench/core_sva.sv
bench/core_tb.sv
